// ==== build.f ====
verilog/reg_map_pkg.sv
verilog/clk_ctrl_pkg.sv
verilog/flag_sync.sv
verilog/phase_shift_ctrl.sv
verilog/control_reg.sv
verilog/wb_access_fsm.sv
verilog/turfio_register_core.sv
test/tb_clocks.sv
test/turfio_register_core_sva.sv
test/turfio_register_core_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
    --top-module turfio_register_core_tb -f build.f -o turfio_sim &&
./obj_dir/turfio_sim ||
{ echo "simulation failed"; exit 1; }

// ==== test/turfio_register_core_tb.sv ====
`timescale 1ns/1ns

module turfio_register_core_tb
    import reg_map_pkg::*, clk_ctrl_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 20000;

    logic                wb_clk_i;
    logic                rxclk_i;
    logic                wb_rst_i;
    logic                wb_cyc_i;
    logic                wb_stb_i;
    logic                wb_we_i;
    logic [ADR_BITS-1:0] wb_adr_i;
    logic [31:0]         wb_dat_i;
    logic [3:0]          wb_sel_i;
    logic [31:0]         wb_dat_o;
    logic                wb_ack_o;
    logic                rxclk_ok_i;
    logic                cin_active_i;
    logic                cin_active_rst_o;
    logic                cin_rst_o;
    logic                train_en_o;
    logic                ps_en_o;
    logic                ps_done_i        = 1'b0;
    logic                mmcm_locked_i    = 1'b0;
    logic                mmcm_rst_o;
    logic                en_vtc_o;
    delay_cmd_t          delay_o;
    logic [DLY_BITS-1:0] delay_cntvalueout_i;
    logic                idelayctrl_rdy_i = 1'b0;
    logic                idelayctrl_rst_o;

    logic [DLY_BITS-1:0] dly_regs [4] = '{default: '0};
    logic [DLY_BITS-1:0] dly_exp [4]  = '{default: '0};
    int                  done_wait    = 0;
    int                  ps_pulses    = 0;
    int                  load_count   = 0;
    int                  rd_count     = 0;
    int                  rst_pulses   = 0;
    int unsigned         seed_val;
    int                  start;
    int                  cycles;
    logic [31:0]         wr;
    logic [31:0]         rdata;
    logic [7:0]          ctrl_low     = '0;
    ps_value_t           target_exp   = '0;

    tb_clocks u_clocks (
        .wb_clk_o (wb_clk_i),
        .rxclk_o  (rxclk_i),
        .wb_rst_o (wb_rst_i)
    );

    turfio_register_core dut_i (.*);

    ////////////////////////////////////////
    // peripheral models
    ////////////////////////////////////////

    // mmcm answers each step after 1 to 4 cycles
    always @(negedge wb_clk_i) begin
        ps_done_i <= 1'b0;
        if (ps_en_o) begin
            done_wait = 1 + ($urandom % 4);
        end else if (done_wait > 0) begin
            done_wait = done_wait - 1;
            if (done_wait == 0)
                ps_done_i <= 1'b1;
        end
    end

    always @(posedge wb_clk_i) begin
        if (ps_en_o)
            ps_pulses <= ps_pulses + 1;
    end

    // locked and ready follow their resets
    always @(negedge wb_clk_i) begin
        mmcm_locked_i    <= !mmcm_rst_o;
        idelayctrl_rdy_i <= !idelayctrl_rst_o;
    end

    // idelay bank with one register per select
    always @(negedge rxclk_i) begin
        if (delay_o.load) begin
            dly_regs[delay_o.sel] <= delay_o.value;
            load_count            <= load_count + 1;
        end
        if (delay_o.rd)
            rd_count <= rd_count + 1;
        if (cin_active_rst_o)
            rst_pulses <= rst_pulses + 1;
    end

    assign delay_cntvalueout_i = dly_regs[delay_o.sel];

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    task automatic timeout_fail(input string what);
        $display("Timeout at %0t ns: %s", $time, what);
        $display("STATUS: FAIL");
        $fatal(1, "timeout");
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got == exp) else begin
            $display("Error at %0t ns: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
            $display("STATUS: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge wb_clk_i);
    endtask

    // drives on a falling edge and returns one idle cycle after ack
    task automatic bus_cycle(input logic we, input logic [ADR_BITS-1:0] adr,
                             input logic [31:0] dat, input logic [3:0] sel,
                             output logic [31:0] data);
        int n;
        n        = 0;
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = we;
        wb_adr_i = adr;
        wb_dat_i = dat;
        wb_sel_i = sel;
        @(negedge wb_clk_i);
        while (!wb_ack_o) begin
            if (n == TIMEOUT_CYCLES)
                timeout_fail("wishbone access got no ack");
            @(negedge wb_clk_i);
            n++;
        end
        data     = wb_dat_o;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        @(negedge wb_clk_i);
    endtask

    task automatic bus_write(input logic [ADR_BITS-1:0] adr, input logic [31:0] dat,
                             input logic [3:0] sel);
        logic [31:0] unused;
        bus_cycle(1'b1, adr, dat, sel, unused);
    endtask

    task automatic bus_read(input logic [ADR_BITS-1:0] adr, output logic [31:0] data);
        bus_cycle(1'b0, adr, 32'd0, 4'hf, data);
    endtask

    // bits 3 and 5 come from the status model and bit 7 from cin_active_i
    function automatic logic [31:0] ctrl_expect(input logic [7:0] low, input ps_value_t tgt,
                                                input logic busy);
        logic [31:0] w;
        w        = '0;
        w[0]     = low[0];
        w[1]     = low[1];
        w[2]     = low[2];
        w[3]     = !low[2];
        w[4]     = low[4];
        w[5]     = !low[4];
        w[6]     = low[6];
        w[7]     = cin_active_i;
        w[25:16] = tgt;
        w[31]    = busy;
        return w;
    endfunction

    task automatic move_phase(input ps_value_t new_t);
        int          first;
        int          polls;
        int          steps;
        logic [31:0] data;
        first = ps_pulses;
        polls = 0;
        steps = (int'(new_t) - int'(target_exp) + PS_MAX + 1) % (PS_MAX + 1);
        bus_write(CONTROL_ADR, {6'd0, new_t, 16'd0}, 4'b1100);
        bus_read(CONTROL_ADR, data);
        while (data[31]) begin
            if (polls == TIMEOUT_CYCLES)
                timeout_fail("phase shift never completed");
            bus_read(CONTROL_ADR, data);
            polls++;
        end
        target_exp = new_t;
        check_value("control word after phase shift", data,
                    ctrl_expect(ctrl_low, target_exp, 1'b0));
        check_value("phase shift step count", ps_pulses - first, steps);
    endtask

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////

    initial begin
        seed_val     = $urandom(83245);
        wb_cyc_i     = 1'b0;
        wb_stb_i     = 1'b0;
        wb_we_i      = 1'b0;
        wb_adr_i     = '0;
        wb_dat_i     = '0;
        wb_sel_i     = '0;
        rxclk_ok_i   = 1'b1;
        cin_active_i = 1'b0;

        cycles = 0;
        @(negedge wb_clk_i);
        while (wb_rst_i) begin
            if (cycles == 100)
                timeout_fail("reset was never released");
            @(negedge wb_clk_i);
            cycles++;
        end
        idle_cycles(4);

        // the second phase move wraps past 671
        move_phase(ps_value_t'($urandom % (PS_MAX + 1)));
        move_phase(target_exp / 2);

        // lane 0 writes leave the target alone
        repeat (4) begin
            wr = $urandom;
            bus_write(CONTROL_ADR, wr, 4'b0001);
            ctrl_low = wr[7:0];
            idle_cycles(8);
            bus_read(CONTROL_ADR, rdata);
            check_value("control word", rdata, ctrl_expect(ctrl_low, target_exp, 1'b0));
            check_value("en_vtc_o", {31'd0, en_vtc_o}, {31'd0, !ctrl_low[1]});
            check_value("control outputs",
                        {28'd0, cin_rst_o, idelayctrl_rst_o, mmcm_rst_o, train_en_o},
                        {28'd0, ctrl_low[0], ctrl_low[2], ctrl_low[4], ctrl_low[6]});
        end

        // one upper lane alone is not enough
        start = ps_pulses;
        bus_write(CONTROL_ADR, $urandom, 4'b0100);
        idle_cycles(4);
        bus_read(CONTROL_ADR, rdata);
        check_value("control word after lane 2 write", rdata,
                    ctrl_expect(ctrl_low, target_exp, 1'b0));
        check_value("steps after lane 2 write", ps_pulses - start, 0);

        // aclk window reads back the control word
        bus_read(11'h040, rdata);
        check_value("aclk window read", rdata, ctrl_expect(ctrl_low, target_exp, 1'b0));

        move_phase(ps_value_t'($urandom % (PS_MAX + 1)));

        ////////////////////////////////////////
        // rxclk delay registers
        ////////////////////////////////////////

        for (int k = 0; k < 4; k++) begin
            wr    = $urandom;
            start = load_count;
            bus_write(RXCLK_DOMAIN + 11'(4 * k), wr, 4'b0011);
            dly_exp[k] = wr[DLY_BITS-1:0];
            check_value("delay load count", load_count - start, 1);
        end

        // only one low lane gives an ack without a load
        start = load_count;
        bus_write(RXCLK_DOMAIN + 11'd4, $urandom, 4'b0001);
        check_value("load count after partial write", load_count - start, 0);

        for (int k = 0; k < 4; k++) begin
            start = rd_count;
            bus_read(RXCLK_DOMAIN + 11'(4 * k), rdata);
            check_value("delay read", rdata, {{(32-DLY_BITS){1'b0}}, dly_exp[k]});
            check_value("delay read pulses", rd_count - start, 1);
        end

        // dead rxclk reads as all ones
        rxclk_ok_i = 1'b0;
        bus_read(RXCLK_DOMAIN + 11'd8, rdata);
        check_value("read with rxclk not ok", rdata, 32'hffff_ffff);
        rxclk_ok_i = 1'b1;
        idle_cycles(20);

        ////////////////////////////////////////
        // cin_active reset
        ////////////////////////////////////////

        cin_active_i = 1'b1;
        idle_cycles(4);
        start = rst_pulses;
        bus_write(CONTROL_ADR, {24'd0, ctrl_low & 8'h7f}, 4'b0001);
        cycles = 0;
        while (rst_pulses == start) begin
            if (cycles == TIMEOUT_CYCLES)
                timeout_fail("cin_active reset pulse never arrived");
            @(negedge wb_clk_i);
            cycles++;
        end
        idle_cycles(10);
        check_value("cin_active_rst_o pulses", rst_pulses - start, 1);

        // writing a 1 back sends nothing
        start = rst_pulses;
        bus_write(CONTROL_ADR, {24'd0, ctrl_low | 8'h80}, 4'b0001);
        idle_cycles(10);
        check_value("cin_active_rst_o pulses after bit 7 set", rst_pulses - start, 0);
        bus_read(CONTROL_ADR, rdata);
        check_value("control word with cin_active", rdata,
                    ctrl_expect(ctrl_low, target_exp, 1'b0));

        $display("STATUS: PASS");
        $finish;
    end

endmodule

// ==== test/turfio_register_core_sva.sv ====
`timescale 1ns/1ns

module turfio_register_core_sva
    import reg_map_pkg::*, clk_ctrl_pkg::*;
(
    input logic                wb_clk_i,
    input logic                wb_rst_i,
    input logic                rxclk_i,
    input logic                wb_cyc_i,
    input logic                wb_stb_i,
    input logic                wb_ack_o,
    input logic [ADR_BITS-1:0] wb_adr_i,
    input logic [31:0]         wb_dat_i,
    input logic                ps_en_o,
    input logic                ps_done_i,
    input logic                cin_active_rst_o,
    input delay_cmd_t          delay_o
);

    logic                req_d    = 1'b0;
    logic                owed     = 1'b0;
    logic [ADR_BITS-1:0] adr_hold = '0;
    logic [31:0]         dat_hold = '0;
    logic                ctrl_start;

    // first cycle of a request outside the rxclk window
    assign ctrl_start = wb_cyc_i && wb_stb_i && !req_d &&
                        ((wb_adr_i & DOMAIN_MASK) != RXCLK_DOMAIN);

    always @(posedge wb_clk_i) begin
        req_d <= wb_cyc_i && wb_stb_i;
        if (wb_cyc_i && wb_stb_i) begin
            adr_hold <= wb_adr_i;
            dat_hold <= wb_dat_i;
        end
    end

    // a phase step is owed a done before the next one
    always @(posedge wb_clk_i) begin
        if (wb_rst_i)
            owed <= 1'b0;
        else if (ps_en_o)
            owed <= 1'b1;
        else if (ps_done_i)
            owed <= 1'b0;
    end

    ////////////////////////////////////////
    // wishbone clock
    ////////////////////////////////////////

    a_ack_single: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
        wb_ack_o |=> !wb_ack_o)
        else $error("wb_ack_o stayed high for more than one cycle");

    a_ctrl_not_early: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
        $past(ctrl_start) |-> !wb_ack_o)
        else $error("control access acked one cycle after the request");

    a_ctrl_latency: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
        $past(ctrl_start, 2) |-> wb_ack_o)
        else $error("control access not acked two cycles after the request");

    a_ps_single: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
        ps_en_o |=> !ps_en_o)
        else $error("ps_en_o longer than one cycle");

    a_ps_done: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
        ps_en_o |-> !owed)
        else $error("ps_en_o pulsed again before ps_done_i");

    ////////////////////////////////////////
    // rxclk
    ////////////////////////////////////////

    a_load_single: assert property (@(posedge rxclk_i) disable iff (wb_rst_i)
        delay_o.load |=> !delay_o.load)
        else $error("delay load longer than one rxclk cycle");

    a_load_rd: assert property (@(posedge rxclk_i) disable iff (wb_rst_i)
        !(delay_o.load && delay_o.rd))
        else $error("delay load and read pulsed together");

    a_load_fields: assert property (@(posedge rxclk_i) disable iff (wb_rst_i)
        delay_o.load |-> (delay_o.sel == adr_hold[3:2]) &&
                         (delay_o.value == dat_hold[DLY_BITS-1:0]))
        else $error("delay load select or value does not match the request");

    a_rst_single: assert property (@(posedge rxclk_i) disable iff (wb_rst_i)
        cin_active_rst_o |=> !cin_active_rst_o)
        else $error("cin_active_rst_o longer than one rxclk cycle");

endmodule

bind turfio_register_core turfio_register_core_sva u_sva (
    .wb_clk_i         (wb_clk_i),
    .wb_rst_i         (wb_rst_i),
    .rxclk_i          (rxclk_i),
    .wb_cyc_i         (wb_cyc_i),
    .wb_stb_i         (wb_stb_i),
    .wb_ack_o         (wb_ack_o),
    .wb_adr_i         (wb_adr_i),
    .wb_dat_i         (wb_dat_i),
    .ps_en_o          (ps_en_o),
    .ps_done_i        (ps_done_i),
    .cin_active_rst_o (cin_active_rst_o),
    .delay_o          (delay_o)
);

// ==== test/tb_clocks.sv ====
`timescale 1ns/1ns

module tb_clocks (
    output logic wb_clk_o,
    output logic rxclk_o,
    output logic wb_rst_o
);

    int half_cnt;

    initial begin
        wb_clk_o = 1'b0;
        forever #5 wb_clk_o = !wb_clk_o;
    end

    // 1 ns steps, so half periods of 3 and 4 average out to 6.4 ns
    initial begin
        rxclk_o  = 1'b0;
        half_cnt = 0;
        forever begin
            #((half_cnt % 5 == 4) ? 4 : 3);
            rxclk_o  = !rxclk_o;
            half_cnt = half_cnt + 1;
        end
    end

    // held over 8 rising edges, released on a falling edge
    initial begin
        wb_rst_o = 1'b1;
        repeat (8) @(posedge wb_clk_o);
        @(negedge wb_clk_o);
        wb_rst_o = 1'b0;
    end

endmodule

// ==== verilog/turfio_register_core.sv ====
`timescale 1ns/1ns

module turfio_register_core
    import reg_map_pkg::*, clk_ctrl_pkg::*;
(
    input  logic                wb_clk_i,
    input  logic                wb_rst_i,
    input  logic                wb_cyc_i,
    input  logic                wb_stb_i,
    input  logic                wb_we_i,
    input  logic [ADR_BITS-1:0] wb_adr_i,
    input  logic [31:0]         wb_dat_i,
    input  logic [3:0]          wb_sel_i,
    output logic [31:0]         wb_dat_o,
    output logic                wb_ack_o,

    input  logic                rxclk_i,
    input  logic                rxclk_ok_i,

    // training status and control
    input  logic                cin_active_i,
    output logic                cin_active_rst_o,
    output logic                cin_rst_o,
    output logic                train_en_o,

    // mmcm and its fine phase shift
    output logic                ps_en_o,
    input  logic                ps_done_i,
    input  logic                mmcm_locked_i,
    output logic                mmcm_rst_o,

    // idelay and idelayctrl
    output logic                en_vtc_o,
    output delay_cmd_t          delay_o,
    input  logic [DLY_BITS-1:0] delay_cntvalueout_i,
    input  logic                idelayctrl_rdy_i,
    output logic                idelayctrl_rst_o
);

    wb_req_t     req;
    logic        ctrl_wr;
    logic [31:0] ctrl_word;
    ps_value_t   target;
    logic        incomplete;

    wb_access_fsm u_wb_access_fsm (
        .wb_clk_i            (wb_clk_i),
        .wb_rst_i            (wb_rst_i),
        .rxclk_i             (rxclk_i),
        .rxclk_ok_i          (rxclk_ok_i),
        .wb_cyc_i            (wb_cyc_i),
        .wb_stb_i            (wb_stb_i),
        .wb_we_i             (wb_we_i),
        .wb_adr_i            (wb_adr_i),
        .wb_dat_i            (wb_dat_i),
        .wb_sel_i            (wb_sel_i),
        .ctrl_word_i         (ctrl_word),
        .delay_cntvalueout_i (delay_cntvalueout_i),
        .wb_dat_o            (wb_dat_o),
        .wb_ack_o            (wb_ack_o),
        .ctrl_wr_o           (ctrl_wr),
        .req_o               (req),
        .delay_o             (delay_o)
    );

    control_reg u_control_reg (
        .wb_clk_i         (wb_clk_i),
        .wb_rst_i         (wb_rst_i),
        .rxclk_i          (rxclk_i),
        .ctrl_wr_i        (ctrl_wr),
        .req_i            (req),
        .incomplete_i     (incomplete),
        .cin_active_i     (cin_active_i),
        .mmcm_locked_i    (mmcm_locked_i),
        .idelayctrl_rdy_i (idelayctrl_rdy_i),
        .ctrl_word_o      (ctrl_word),
        .target_o         (target),
        .cin_rst_o        (cin_rst_o),
        .en_vtc_o         (en_vtc_o),
        .idelayctrl_rst_o (idelayctrl_rst_o),
        .mmcm_rst_o       (mmcm_rst_o),
        .train_en_o       (train_en_o),
        .cin_active_rst_o (cin_active_rst_o)
    );

    phase_shift_ctrl u_phase_shift_ctrl (
        .wb_clk_i     (wb_clk_i),
        .wb_rst_i     (wb_rst_i),
        .target_i     (target),
        .ps_done_i    (ps_done_i),
        .ps_en_o      (ps_en_o),
        .incomplete_o (incomplete)
    );

endmodule

// ==== verilog/wb_access_fsm.sv ====
`timescale 1ns/1ns

module wb_access_fsm
    import reg_map_pkg::*, clk_ctrl_pkg::*;
(
    input  logic                wb_clk_i,
    input  logic                wb_rst_i,
    input  logic                rxclk_i,
    input  logic                rxclk_ok_i,
    input  logic                wb_cyc_i,
    input  logic                wb_stb_i,
    input  logic                wb_we_i,
    input  logic [ADR_BITS-1:0] wb_adr_i,
    input  logic [31:0]         wb_dat_i,
    input  logic [3:0]          wb_sel_i,
    input  logic [31:0]         ctrl_word_i,
    input  logic [DLY_BITS-1:0] delay_cntvalueout_i,
    output logic [31:0]         wb_dat_o,
    output logic                wb_ack_o,
    output logic                ctrl_wr_o,
    output wb_req_t             req_o,
    output delay_cmd_t          delay_o
);

    typedef enum logic [1:0] {
        IDLE       = 2'd0,
        ACK        = 2'd1,
        WAIT_RXCLK = 2'd2
    } state_t;

    state_t state;
    logic   accept;
    logic   rxclk_access;
    logic   rx_window;
    logic   rx_go_wb;
    logic   rx_go_rx;
    logic   rx_ret_rx = 1'b0;
    logic   rx_ret_wb;

    // ack is still high on the edge the master sees it
    assign accept       = (state == IDLE) && wb_cyc_i && wb_stb_i && !wb_ack_o;
    assign rxclk_access = (wb_adr_i & DOMAIN_MASK) == RXCLK_DOMAIN;
    assign rx_window    = (req_o.adr & DOMAIN_MASK) == RXCLK_DOMAIN;

    ////////////////////////////////////////
    // request capture
    ////////////////////////////////////////

    always_ff @(posedge wb_clk_i) begin
        if (accept) begin
            req_o.adr <= wb_adr_i;
            req_o.sel <= wb_sel_i;
            req_o.we  <= wb_we_i;
            for (int i = 0; i < 4; i++) begin
                if (wb_sel_i[i])
                    req_o.dat[8*i +: 8] <= wb_dat_i[8*i +: 8];
            end
        end
    end

    ////////////////////////////////////////
    // access FSM
    ////////////////////////////////////////

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            state    <= IDLE;
            wb_ack_o <= 1'b0;
            rx_go_wb <= 1'b0;
        end else begin
            wb_ack_o <= (state == ACK);
            // first cycle of WAIT_RXCLK
            rx_go_wb <= accept && rxclk_access;
            case (state)
                IDLE: begin
                    if (accept)
                        state <= rxclk_access ? WAIT_RXCLK : ACK;
                end
                ACK: state <= IDLE;
                WAIT_RXCLK: begin
                    // a dead rxclk must not hang the bus
                    if (rx_ret_wb || !rxclk_ok_i)
                        state <= ACK;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // read data lines up with the registered ack
    always_ff @(posedge wb_clk_i) begin
        if (state == WAIT_RXCLK) begin
            if (rx_ret_wb)
                wb_dat_o <= {{(32-DLY_BITS){1'b0}}, delay_cntvalueout_i};
            else if (!rxclk_ok_i)
                wb_dat_o <= '1;
        end else if (state == ACK && !rx_window) begin
            wb_dat_o <= ctrl_word_i;
        end
    end

    assign ctrl_wr_o = (state == ACK) && req_o.we &&
                       ((req_o.adr & (DOMAIN_MASK | REG_MASK)) == CONTROL_ADR);

    ////////////////////////////////////////
    // rxclk handshake
    ////////////////////////////////////////

    flag_sync u_go_sync (
        .clk_a_i  (wb_clk_i),
        .clk_b_i  (rxclk_i),
        .flag_a_i (rx_go_wb),
        .flag_b_o (rx_go_rx)
    );

    // one rxclk later the delay value is settled
    always_ff @(posedge rxclk_i) begin
        rx_ret_rx <= rx_go_rx;
    end

    flag_sync u_ret_sync (
        .clk_a_i  (rxclk_i),
        .clk_b_i  (wb_clk_i),
        .flag_a_i (rx_ret_rx),
        .flag_b_o (rx_ret_wb)
    );

    // load needs both low lanes, anything else is just acked
    always_comb begin
        delay_o.load  = rx_go_rx && req_o.we && req_o.sel[0] && req_o.sel[1];
        delay_o.rd    = rx_go_rx && !req_o.we;
        delay_o.sel   = req_o.adr[3:2];
        delay_o.value = req_o.dat[DLY_BITS-1:0];
    end

endmodule

// ==== verilog/control_reg.sv ====
`timescale 1ns/1ns

module control_reg
    import reg_map_pkg::*, clk_ctrl_pkg::*;
(
    input  logic        wb_clk_i,
    input  logic        wb_rst_i,
    input  logic        rxclk_i,
    input  logic        ctrl_wr_i,
    input  wb_req_t     req_i,
    input  logic        incomplete_i,
    input  logic        cin_active_i,
    input  logic        mmcm_locked_i,
    input  logic        idelayctrl_rdy_i,
    output logic [31:0] ctrl_word_o,
    output ps_value_t   target_o,
    output logic        cin_rst_o,
    output logic        en_vtc_o,
    output logic        idelayctrl_rst_o,
    output logic        mmcm_rst_o,
    output logic        train_en_o,
    output logic        cin_active_rst_o
);

    logic       dis_vtc;
    logic       cin_active_rst;
    logic [2:0] status_meta;
    logic [2:0] status_sync;
    logic       cin_active_s;
    logic       mmcm_locked_s;
    logic       idelayctrl_rdy_s;

    ////////////////////////////////////////
    // status inputs
    ////////////////////////////////////////

    always_ff @(posedge wb_clk_i) begin
        status_meta <= {cin_active_i, mmcm_locked_i, idelayctrl_rdy_i};
        status_sync <= status_meta;
    end

    assign {cin_active_s, mmcm_locked_s, idelayctrl_rdy_s} = status_sync;

    ////////////////////////////////////////
    // register writes
    ////////////////////////////////////////

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            cin_rst_o        <= 1'b0;
            dis_vtc          <= 1'b0;
            idelayctrl_rst_o <= 1'b0;
            mmcm_rst_o       <= 1'b0;
            train_en_o       <= 1'b0;
            target_o         <= '0;
            cin_active_rst   <= 1'b0;
        end else begin
            cin_active_rst <= 1'b0;
            if (ctrl_wr_i) begin
                if (req_i.sel[0]) begin
                    cin_rst_o        <= req_i.dat[CTRL_CIN_RST];
                    dis_vtc          <= req_i.dat[CTRL_DIS_VTC];
                    idelayctrl_rst_o <= req_i.dat[CTRL_IDCTRL_RST];
                    mmcm_rst_o       <= req_i.dat[CTRL_MMCM_RST];
                    train_en_o       <= req_i.dat[CTRL_TRAIN_EN];
                    // inverted sense so a read-modify-write of a 1 leaves it alone
                    cin_active_rst   <= !req_i.dat[CTRL_CIN_ACTIVE] && cin_active_s;
                end
                // target only moves on a full upper half-word
                if (req_i.sel[2] && req_i.sel[3])
                    target_o <= req_i.dat[CTRL_PS_LSB +: PS_BITS];
            end
        end
    end

    assign en_vtc_o = !dis_vtc;

    flag_sync u_cin_active_rst_sync (
        .clk_a_i  (wb_clk_i),
        .clk_b_i  (rxclk_i),
        .flag_a_i (cin_active_rst),
        .flag_b_o (cin_active_rst_o)
    );

    // read word with unused bits at zero
    always_comb begin
        ctrl_word_o                          = '0;
        ctrl_word_o[CTRL_CIN_RST]            = cin_rst_o;
        ctrl_word_o[CTRL_DIS_VTC]            = dis_vtc;
        ctrl_word_o[CTRL_IDCTRL_RST]         = idelayctrl_rst_o;
        ctrl_word_o[CTRL_IDCTRL_RDY]         = idelayctrl_rdy_s;
        ctrl_word_o[CTRL_MMCM_RST]           = mmcm_rst_o;
        ctrl_word_o[CTRL_MMCM_LOCKED]        = mmcm_locked_s;
        ctrl_word_o[CTRL_TRAIN_EN]           = train_en_o;
        ctrl_word_o[CTRL_CIN_ACTIVE]         = cin_active_s;
        ctrl_word_o[CTRL_PS_LSB +: PS_BITS]  = target_o;
        ctrl_word_o[CTRL_PS_INCOMPLETE]      = incomplete_i;
    end

endmodule

// ==== verilog/phase_shift_ctrl.sv ====
`timescale 1ns/1ns

module phase_shift_ctrl
    import clk_ctrl_pkg::*;
(
    input  logic      wb_clk_i,
    input  logic      wb_rst_i,
    input  ps_value_t target_i,
    input  logic      ps_done_i,
    output logic      ps_en_o,
    output logic      incomplete_o
);

    ps_value_t current;
    logic      waiting;

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            current      <= '0;
            waiting      <= 1'b0;
            ps_en_o      <= 1'b0;
            incomplete_o <= 1'b0;
        end else begin
            // one step at a time, never while a done is owed
            ps_en_o <= (target_i != current) && !waiting && !ps_en_o;

            if (ps_en_o) begin
                waiting <= 1'b1;
                if (current == ps_value_t'(PS_MAX))
                    current <= '0;
                else
                    current <= current + 1'b1;
            end else if (ps_done_i) begin
                waiting <= 1'b0;
            end

            incomplete_o <= (target_i != current) || waiting || ps_en_o;
        end
    end

endmodule

// ==== verilog/flag_sync.sv ====
`timescale 1ns/1ns

module flag_sync (
    input  logic clk_a_i,
    input  logic clk_b_i,
    input  logic flag_a_i,
    output logic flag_b_o
);

    // level that flips once per source pulse
    logic       toggle_a = 1'b0;
    logic [2:0] sync_b   = 3'b000;

    always_ff @(posedge clk_a_i) begin
        toggle_a <= toggle_a ^ flag_a_i;
    end

    // first two stages resolve metastability
    always_ff @(posedge clk_b_i) begin
        sync_b <= {sync_b[1:0], toggle_a};
    end

    // any edge of the synchronized level is one pulse
    assign flag_b_o = sync_b[2] ^ sync_b[1];

endmodule

// ==== verilog/clk_ctrl_pkg.sv ====
package clk_ctrl_pkg;

    ////////////////////////////////////////
    // fine phase shift
    ////////////////////////////////////////

    // 56 steps per vco period times 12, counted from zero
    localparam int PS_MAX  = 671;
    localparam int PS_BITS = 10;

    typedef logic [PS_BITS-1:0] ps_value_t;

    ////////////////////////////////////////
    // rxclk delay access
    ////////////////////////////////////////

    localparam int DLY_BITS = 9;

    typedef struct packed {
        logic                load;
        logic                rd;
        logic [1:0]          sel;
        logic [DLY_BITS-1:0] value;
    } delay_cmd_t;

endpackage

// ==== verilog/reg_map_pkg.sv ====
package reg_map_pkg;

    ////////////////////////////////////////
    // wishbone address map
    ////////////////////////////////////////

    localparam int ADR_BITS = 11;

    // upper bits pick the clock domain, lower bits the register
    localparam logic [ADR_BITS-1:0] DOMAIN_MASK  = 11'h0C0;
    localparam logic [ADR_BITS-1:0] REG_MASK     = 11'h03F;
    localparam logic [ADR_BITS-1:0] CONTROL_ADR  = 11'h000;
    localparam logic [ADR_BITS-1:0] RXCLK_DOMAIN = 11'h080;

    ////////////////////////////////////////
    // control register bits
    ////////////////////////////////////////

    localparam int CTRL_CIN_RST       = 0;
    localparam int CTRL_DIS_VTC       = 1;
    localparam int CTRL_IDCTRL_RST    = 2;
    localparam int CTRL_IDCTRL_RDY    = 3;
    localparam int CTRL_MMCM_RST      = 4;
    localparam int CTRL_MMCM_LOCKED   = 5;
    localparam int CTRL_TRAIN_EN      = 6;
    localparam int CTRL_CIN_ACTIVE    = 7;
    localparam int CTRL_PS_LSB        = 16;
    localparam int CTRL_PS_INCOMPLETE = 31;

    // request as held for the whole access
    typedef struct packed {
        logic [ADR_BITS-1:0] adr;
        logic [31:0]         dat;
        logic [3:0]          sel;
        logic                we;
    } wb_req_t;

endpackage
